// File: miss_defs.svh
`ifndef MISS_DEFS_SVH
`define MISS_DEFS_SVH

// load side
`define LOAD_PIPES        2
`define WAITERS_PER_PIPE  4
`define LQ_IDX_BITS       5

// miss queue
`define MISS_ENTRIES      4

// address and data
`define PADDR_BITS        32
`define WORD_BITS         32
`define LINE_WORDS        4

// derived widths
`define MISS_IDX_BITS     ($clog2(`MISS_ENTRIES))
`define WORD_SEL_BITS     ($clog2(`LINE_WORDS))
`define LINE_ADDR_BITS    (`PADDR_BITS - `WORD_SEL_BITS - 2)

`endif

// File: miss_pkg.sv
`include "miss_defs.svh"

package miss_pkg;

    typedef logic [`WORD_BITS-1:0] word_t;

    // word 0 sits in the low bits
    typedef word_t [`LINE_WORDS-1:0] line_t;

    typedef logic [`MISS_IDX_BITS-1:0] miss_idx_t;

    typedef logic [`LQ_IDX_BITS-1:0] lq_idx_t;

    typedef struct packed {
        logic [`LINE_ADDR_BITS-1:0] line_addr;
        logic [`WORD_SEL_BITS-1:0]  word_sel;
        logic [1:0]                 byte_sel;
    } paddr_fields_t;

    // loads are decoded through f, bus addresses are built raw
    typedef union packed {
        logic [`PADDR_BITS-1:0] raw;
        paddr_fields_t          f;
    } paddr_u;

endpackage

// File: miss_table.sv
`timescale 1ns/10ps
`include "miss_defs.svh"

module miss_table import miss_pkg::*; (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [`LOAD_PIPES-1:0]       ren,
    input  paddr_u [`LOAD_PIPES-1:0]     raddr,
    input  logic [`LOAD_PIPES-1:0]       slot_free,
    input  logic                         refill_done,
    input  logic                         retire,
    output logic [`LOAD_PIPES-1:0]       rfull,
    output logic [`LOAD_PIPES-1:0]       accept,
    output miss_idx_t [`LOAD_PIPES-1:0]  accept_idx,
    output miss_idx_t                    head_idx,
    output logic                         head_valid,
    output logic [`LINE_ADDR_BITS-1:0]   head_line
);

    localparam int CNT_BITS = `MISS_IDX_BITS + 1;

    // entry state
    logic [`MISS_ENTRIES-1:0]    valid;
    logic [`MISS_ENTRIES-1:0]    matchable;
    logic [`LINE_ADDR_BITS-1:0]  line_addr [`MISS_ENTRIES];
    miss_idx_t                   head;
    miss_idx_t                   tail;
    logic [CNT_BITS-1:0]         free_cnt;

    // per pipe lookup
    logic [`LOAD_PIPES-1:0]      hit;
    logic [`LOAD_PIPES-1:0]      pair_hit;
    logic [`LOAD_PIPES-1:0]      alloc;
    miss_idx_t [`LOAD_PIPES-1:0] hit_idx;
    miss_idx_t [`LOAD_PIPES-1:0] pair_idx;
    miss_idx_t [`LOAD_PIPES-1:0] alloc_idx;
    logic [CNT_BITS-1:0]         n_alloc;

    // compare each load line against the matchable entries
    always_comb begin
        for (int i = 0; i < `LOAD_PIPES; i++) begin
            hit[i] = 1'b0;
            hit_idx[i] = '0;
            for (int j = `MISS_ENTRIES - 1; j >= 0; j--) begin
                if (matchable[j] && line_addr[j] == raddr[i].f.line_addr) begin
                    hit[i] = 1'b1;
                    hit_idx[i] = miss_idx_t'(j);
                end
            end
        end
    end

    // allocation in pipe order; a higher pipe may join a lower pipe's new entry
    always_comb begin
        n_alloc = '0;
        alloc = '0;
        alloc_idx = '0;
        pair_hit = '0;
        pair_idx = '0;
        accept = '0;
        accept_idx = '0;
        for (int i = 0; i < `LOAD_PIPES; i++) begin
            for (int k = 0; k < `LOAD_PIPES; k++) begin
                if (k < i && alloc[k] &&
                    raddr[k].f.line_addr == raddr[i].f.line_addr) begin
                    pair_hit[i] = 1'b1;
                    pair_idx[i] = alloc_idx[k];
                end
            end
            alloc_idx[i] = tail + n_alloc[`MISS_IDX_BITS-1:0];
            alloc[i] = ren[i] && slot_free[i] && !hit[i] && !pair_hit[i] &&
                       (free_cnt > n_alloc);
            n_alloc = n_alloc + CNT_BITS'(alloc[i]);
            accept[i] = ren[i] && slot_free[i] && (hit[i] || pair_hit[i] || alloc[i]);
            if (hit[i]) begin
                accept_idx[i] = hit_idx[i];
            end else if (pair_hit[i]) begin
                accept_idx[i] = pair_idx[i];
            end else begin
                accept_idx[i] = alloc_idx[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid <= '0;
            matchable <= '0;
            head <= '0;
            tail <= '0;
            free_cnt <= CNT_BITS'(`MISS_ENTRIES);
            rfull <= '0;
        end else begin
            for (int i = 0; i < `LOAD_PIPES; i++) begin
                if (alloc[i]) begin
                    valid[alloc_idx[i]] <= 1'b1;
                    matchable[alloc_idx[i]] <= 1'b1;
                end
            end
            // line handed to the cache, later loads start a new miss
            if (refill_done) begin
                matchable[head] <= 1'b0;
            end
            if (retire) begin
                valid[head] <= 1'b0;
                head <= head + 1'b1;
            end
            tail <= tail + n_alloc[`MISS_IDX_BITS-1:0];
            free_cnt <= free_cnt + CNT_BITS'(retire) - n_alloc;
            rfull <= ren & ~accept;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `LOAD_PIPES; i++) begin
            if (alloc[i]) begin
                line_addr[alloc_idx[i]] <= raddr[i].f.line_addr;
            end
        end
    end

    assign head_idx = head;
    assign head_valid = valid[head];
    assign head_line = line_addr[head];

endmodule

// File: load_waiter_bank.sv
`timescale 1ns/10ps
`include "miss_defs.svh"

module load_waiter_bank import miss_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       accept,
    input  miss_idx_t  accept_idx,
    input  paddr_u     raddr,
    input  lq_idx_t    lq_idx,
    input  logic       wake_valid,
    input  miss_idx_t  wake_idx,
    input  line_t      wake_line,
    output logic       slot_free,
    output logic       wake_pending,
    output logic       lq_en,
    output word_t      lq_data,
    output lq_idx_t    lq_idx_o
);

    localparam int SLOT_BITS = $clog2(`WAITERS_PER_PIPE);

    logic [`WAITERS_PER_PIPE-1:0] slot_valid;
    miss_idx_t                    slot_miss [`WAITERS_PER_PIPE];
    logic [`WORD_SEL_BITS-1:0]    slot_word [`WAITERS_PER_PIPE];
    lq_idx_t                      slot_lq [`WAITERS_PER_PIPE];

    logic [`WAITERS_PER_PIPE-1:0] wake_hit;
    logic [SLOT_BITS-1:0]         wake_sel;
    logic [SLOT_BITS-1:0]         free_sel;

    // lowest matching waiter and lowest empty slot
    always_comb begin
        wake_sel = '0;
        free_sel = '0;
        for (int s = `WAITERS_PER_PIPE - 1; s >= 0; s--) begin
            wake_hit[s] = wake_valid && slot_valid[s] && slot_miss[s] == wake_idx;
            if (wake_hit[s]) begin
                wake_sel = SLOT_BITS'(s);
            end
            if (!slot_valid[s]) begin
                free_sel = SLOT_BITS'(s);
            end
        end
    end

    assign slot_free = ~&slot_valid;
    assign wake_pending = |wake_hit;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            slot_valid <= '0;
            lq_en <= 1'b0;
        end else begin
            if (accept) begin
                slot_valid[free_sel] <= 1'b1;
            end
            // one waiter leaves per cycle
            if (wake_pending) begin
                slot_valid[wake_sel] <= 1'b0;
            end
            lq_en <= wake_pending;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            slot_miss[free_sel] <= accept_idx;
            slot_word[free_sel] <= raddr.f.word_sel;
            slot_lq[free_sel] <= lq_idx;
        end
        if (wake_pending) begin
            lq_data <= wake_line[slot_word[wake_sel]];
            lq_idx_o <= slot_lq[wake_sel];
        end
    end

endmodule

// File: line_fetcher.sv
`timescale 1ns/10ps
`include "miss_defs.svh"

module line_fetcher import miss_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        head_valid,
    input  logic [`LINE_ADDR_BITS-1:0]  head_line,
    input  miss_idx_t                   head_idx,
    input  logic                        ar_ready,
    input  logic                        r_valid,
    input  logic                        r_last,
    input  word_t                       r_data,
    input  logic                        refill_valid,
    input  logic                        wake_pending,
    output logic                        ar_valid,
    output logic [`PADDR_BITS-1:0]      ar_addr,
    output logic                        refill_en,
    output logic [`PADDR_BITS-1:0]      refill_addr,
    output line_t                       refill_data,
    output logic                        refill_done,
    output logic                        wake_valid,
    output miss_idx_t                   wake_idx,
    output line_t                       wake_line,
    output logic                        retire
);

    localparam logic [2:0] S_IDLE   = 3'd0;
    localparam logic [2:0] S_REQ    = 3'd1;
    localparam logic [2:0] S_BEAT   = 3'd2;
    localparam logic [2:0] S_REFILL = 3'd3;
    localparam logic [2:0] S_WAKE   = 3'd4;

    logic [2:0]                  state;
    logic [`WORD_SEL_BITS-1:0]   beat_cnt;
    logic [`LINE_ADDR_BITS-1:0]  fetch_line;
    miss_idx_t                   fetch_idx;
    line_t                       line_buf;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= S_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (head_valid) begin
                        state <= S_REQ;
                    end
                end
                S_REQ: begin
                    if (ar_ready) begin
                        state <= S_BEAT;
                        beat_cnt <= '0;
                    end
                end
                S_BEAT: begin
                    if (r_valid) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (r_last) begin
                            state <= S_REFILL;
                        end
                    end
                end
                S_REFILL: begin
                    if (refill_valid) begin
                        state <= S_WAKE;
                    end
                end
                S_WAKE: begin
                    // banks drained, entry can go
                    if (!wake_pending) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // oldest miss is latched so the address holds through the burst
    always_ff @(posedge clk) begin
        if (state == S_IDLE && head_valid) begin
            fetch_line <= head_line;
            fetch_idx <= head_idx;
        end
        if (state == S_BEAT && r_valid) begin
            line_buf[beat_cnt] <= r_data;
        end
    end

    assign ar_valid = state == S_REQ;
    assign ar_addr = {fetch_line, {`WORD_SEL_BITS{1'b0}}, 2'b00};

    assign refill_en = state == S_REFILL;
    assign refill_addr = ar_addr;
    assign refill_data = line_buf;
    assign refill_done = refill_en && refill_valid;

    assign wake_valid = state == S_WAKE;
    assign wake_idx = fetch_idx;
    assign wake_line = line_buf;
    assign retire = wake_valid && !wake_pending;

endmodule

// File: dcache_miss.sv
`timescale 1ns/10ps
`include "miss_defs.svh"

module dcache_miss import miss_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`LOAD_PIPES-1:0]      ren,
    input  paddr_u [`LOAD_PIPES-1:0]    raddr,
    input  lq_idx_t [`LOAD_PIPES-1:0]   lq_idx,
    output logic [`LOAD_PIPES-1:0]      rfull,
    output logic                        ar_valid,
    output logic [`PADDR_BITS-1:0]      ar_addr,
    input  logic                        ar_ready,
    input  logic                        r_valid,
    input  logic                        r_last,
    input  word_t                       r_data,
    output logic                        refill_en,
    output logic [`PADDR_BITS-1:0]      refill_addr,
    output line_t                       refill_data,
    input  logic                        refill_valid,
    output logic [`LOAD_PIPES-1:0]      lq_en,
    output word_t [`LOAD_PIPES-1:0]     lq_data,
    output lq_idx_t [`LOAD_PIPES-1:0]   lq_idx_o
);

    logic [`LOAD_PIPES-1:0]       slot_free;
    logic [`LOAD_PIPES-1:0]       accept;
    miss_idx_t [`LOAD_PIPES-1:0]  accept_idx;
    logic [`LOAD_PIPES-1:0]       bank_pending;
    miss_idx_t                    head_idx;
    logic                         head_valid;
    logic [`LINE_ADDR_BITS-1:0]   head_line;
    logic                         refill_done;
    logic                         retire;
    logic                         wake_valid;
    miss_idx_t                    wake_idx;
    line_t                        wake_line;
    logic                         wake_pending;

    miss_table u_miss_table (
        .clk(clk), .rst(rst),
        .ren(ren), .raddr(raddr), .slot_free(slot_free),
        .refill_done(refill_done), .retire(retire),
        .rfull(rfull), .accept(accept), .accept_idx(accept_idx),
        .head_idx(head_idx), .head_valid(head_valid), .head_line(head_line)
    );

    line_fetcher u_line_fetcher (
        .clk(clk), .rst(rst),
        .head_valid(head_valid), .head_line(head_line), .head_idx(head_idx),
        .ar_ready(ar_ready), .r_valid(r_valid), .r_last(r_last), .r_data(r_data),
        .refill_valid(refill_valid), .wake_pending(wake_pending),
        .ar_valid(ar_valid), .ar_addr(ar_addr),
        .refill_en(refill_en), .refill_addr(refill_addr), .refill_data(refill_data),
        .refill_done(refill_done),
        .wake_valid(wake_valid), .wake_idx(wake_idx), .wake_line(wake_line),
        .retire(retire)
    );

    for (genvar p = 0; p < `LOAD_PIPES; p++) begin : g_bank
        load_waiter_bank u_load_waiter_bank (
            .clk(clk), .rst(rst),
            .accept(accept[p]), .accept_idx(accept_idx[p]),
            .raddr(raddr[p]), .lq_idx(lq_idx[p]),
            .wake_valid(wake_valid), .wake_idx(wake_idx), .wake_line(wake_line),
            .slot_free(slot_free[p]), .wake_pending(bank_pending[p]),
            .lq_en(lq_en[p]), .lq_data(lq_data[p]), .lq_idx_o(lq_idx_o[p])
        );
    end

    // fetcher holds the wakeup until every bank is done
    assign wake_pending = |bank_pending;

endmodule

// File: dcache_miss_props.sv
`timescale 1ns/10ps
`include "miss_defs.svh"

module dcache_miss_props import miss_pkg::*; (
    input logic                    clk,
    input logic                    rst,
    input logic [`LOAD_PIPES-1:0]  rfull,
    input logic                    ar_valid,
    input logic [`PADDR_BITS-1:0]  ar_addr,
    input logic                    ar_ready,
    input logic                    r_valid,
    input logic                    r_last,
    input logic                    refill_en,
    input logic [`PADDR_BITS-1:0]  refill_addr,
    input line_t                   refill_data,
    input logic                    refill_valid,
    input logic [`LOAD_PIPES-1:0]  lq_en
);

    int fail_cnt = 0;

    // request holds until accepted
    ar_hold: assert property (@(posedge clk) disable iff (!rst)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
    else begin
        $error("ar_valid or ar_addr changed before ar_ready");
        fail_cnt++;
    end

    refill_hold: assert property (@(posedge clk) disable iff (!rst)
        refill_en && !refill_valid |=>
            refill_en && $stable(refill_addr) && $stable(refill_data))
    else begin
        $error("refill changed before refill_valid");
        fail_cnt++;
    end

    refill_after_last: assert property (@(posedge clk) disable iff (!rst)
        r_valid && r_last |=> $rose(refill_en))
    else begin
        $error("refill_en did not rise one cycle after r_last");
        fail_cnt++;
    end

    refill_only_after_last: assert property (@(posedge clk) disable iff (!rst)
        $rose(refill_en) |-> $past(r_valid && r_last))
    else begin
        $error("refill_en rose without a preceding r_last beat");
        fail_cnt++;
    end

    // quiet outputs right after reset release
    reset_quiet: assert property (@(posedge clk)
        $rose(rst) |-> !ar_valid && !refill_en && rfull == '0 && lq_en == '0)
    else begin
        $error("outputs not idle in the first cycle after reset");
        fail_cnt++;
    end

endmodule

// File: tb_dcache_miss.sv
`timescale 1ns/10ps
`include "miss_defs.svh"

module tb_dcache_miss import miss_pkg::*;;

    logic clk = 0, rst = 0, ar_ready = 0, r_valid = 0, r_last = 0, refill_valid = 0;
    logic [`LOAD_PIPES-1:0] ren = '0, rfull, lq_en;
    paddr_u [`LOAD_PIPES-1:0] raddr = '0;
    lq_idx_t [`LOAD_PIPES-1:0] lq_idx = '0, lq_idx_o;
    word_t r_data = '0;
    word_t [`LOAD_PIPES-1:0] lq_data;
    logic ar_valid, refill_en;
    logic [`PADDR_BITS-1:0] ar_addr, refill_addr, ar_seen;
    line_t refill_data;

    logic [31:0] stim_seed = 43, model_seed = 43;
    logic [31:0] pending = '0;
    logic [31:0] load_addr [32];
    logic hold_ar = 0, in_burst = 0;
    logic [1:0] full;
    int beat = 0, ar_count = 0, refills = 0, errors = 0, tests = 0, next_idx = 0, base;

    dcache_miss u_dcache_miss (.*);

    bind dcache_miss dcache_miss_props u_props (
        .clk(clk), .rst(rst), .rfull(rfull), .ar_valid(ar_valid), .ar_addr(ar_addr),
        .ar_ready(ar_ready), .r_valid(r_valid), .r_last(r_last), .refill_en(refill_en),
        .refill_addr(refill_addr), .refill_data(refill_data),
        .refill_valid(refill_valid), .lq_en(lq_en)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] next_rand(inout logic [31:0] s);
        s = s * 32'd1103515245 + 32'd12345;
        return s >> 16;
    endfunction

    // memory rule, indexed by word address
    function automatic word_t mem_word(input logic [31:0] a);
        return a * 32'h9E3779B1 + 32'd7;
    endfunction

    // small window of lines so loads collide
    function automatic logic [31:0] rand_addr();
        logic [31:0] line;
        logic [31:0] word;
        line = next_rand(stim_seed) % 6;
        word = next_rand(stim_seed) % 4;
        return 32'h2000 + line * 16 + word * 4;
    endfunction

    function automatic int free_idx();
        for (int n = 0; n < 32; n++) begin
            next_idx = (next_idx + 1) % 32;
            if (!pending[next_idx]) begin
                return next_idx;
            end
        end
        return 0;
    endfunction

    // bus and cache handshakes, sampled mid cycle
    always @(negedge clk) begin
        if (ar_valid && ar_ready) begin
            in_burst = 1;
            beat = 0;
            ar_seen = ar_addr;
            ar_count++;
        end
        if (refill_en && refill_valid) begin
            refills++;
            assert (refill_addr == ar_seen && refill_addr[3:0] == 4'h0) else begin
                $display("mismatch at %0t: refill_addr %h, ar_addr %h", $time,
                         refill_addr, ar_seen);
                errors++;
            end
            for (int w = 0; w < `LINE_WORDS; w++) begin
                assert (refill_data[w] == mem_word(refill_addr[31:2] + w)) else begin
                    $display("mismatch at %0t: refill word %0d is %h", $time, w,
                             refill_data[w]);
                    errors++;
                end
            end
        end
    end

    // bus and cache responses
    always @(posedge clk) begin
        #1;
        ar_ready = !hold_ar && next_rand(model_seed) % 3 != 0;
        r_valid = 0;
        r_last = 0;
        if (in_burst && next_rand(model_seed) % 4 != 0) begin
            r_valid = 1;
            r_data = mem_word(ar_seen[31:2] + beat);
            r_last = beat == `LINE_WORDS - 1;
            in_burst = !r_last;
            beat++;
        end
        refill_valid = refill_en && next_rand(model_seed) % 2 == 0;
    end

    // scoreboard on the wakeup ports
    always @(negedge clk) begin
        for (int p = 0; p < `LOAD_PIPES; p++) begin
            if (lq_en[p]) begin
                assert (pending[lq_idx_o[p]]) else begin
                    $display("pipe %0d woke load %0d, which was not waiting", p, lq_idx_o[p]);
                    errors++;
                end
                assert (lq_data[p] == mem_word(load_addr[lq_idx_o[p]] >> 2)) else begin
                    $display("mismatch at %0t: load %0d data %h", $time, lq_idx_o[p],
                             lq_data[p]);
                    errors++;
                end
                pending[lq_idx_o[p]] = 0;
            end
        end
    end

    task automatic issue(input logic [1:0] en, input logic [31:0] a0,
                         input logic [31:0] a1, output logic [1:0] rej);
        logic [31:0] a [2];
        int idx [2];
        a[0] = a0;
        a[1] = a1;
        for (int p = 0; p < 2; p++) begin
            idx[p] = 0;
            if (en[p]) begin
                idx[p] = free_idx();
                pending[idx[p]] = 1;
                load_addr[idx[p]] = a[p];
                lq_idx[p] = lq_idx_t'(idx[p]);
                raddr[p].raw = a[p];
            end
        end
        ren = en;
        @(posedge clk);
        #1;
        ren = '0;
        rej = rfull;
        for (int p = 0; p < 2; p++) begin
            if (en[p] && rfull[p]) begin
                pending[idx[p]] = 0;
            end
        end
    endtask

    task automatic drain(input string name);
        int n;
        for (n = 0; n < 3000 && pending != '0; n++) begin
            @(posedge clk);
        end
        if (pending != '0) begin
            $display("timeout in test %s: waiting loads were never woken", name);
            errors++;
        end
        // last entry retires a cycle after its final wakeup
        repeat (4) @(posedge clk);
        #1;
        tests++;
        $display("test %s done, errors so far %0d", name, errors);
    endtask

    initial begin
        repeat (5) @(posedge clk);
        #1;
        rst = 1;
        @(posedge clk);
        #1;

        for (int i = 0; i < 80; i++) begin
            logic [1:0] en;
            logic [31:0] a0;
            logic [31:0] a1;
            en = 2'(next_rand(stim_seed) % 4);
            a0 = rand_addr();
            a1 = rand_addr();
            issue(en, a0, a1, full);
        end
        drain("random_loads");

        // one line from both pipes and in later cycles
        base = ar_count;
        hold_ar = 1;
        issue(2'b11, 32'h5010, 32'h5018, full);
        issue(2'b01, 32'h5014, 0, full);
        issue(2'b10, 32'h501c, 32'h501c, full);
        hold_ar = 0;
        drain("merge");
        assert (ar_count - base == 1) else begin
            $display("mismatch at %0t: %0d bus reads for one line", $time, ar_count - base);
            errors++;
        end

        hold_ar = 1;
        for (int i = 0; i < `MISS_ENTRIES + 2; i++) begin
            issue(2'b01, 32'h3000 + i * 16, 0, full);
            assert (full[0] == (i >= `MISS_ENTRIES)) else begin
                $display("mismatch at %0t: queue full load %0d rfull %b", $time, i, full[0]);
                errors++;
            end
        end
        hold_ar = 0;
        drain("queue_full");

        hold_ar = 1;
        for (int i = 0; i <= `WAITERS_PER_PIPE; i++) begin
            issue(2'b10, 0, 32'h4000 + (i % 4) * 4, full);
            assert (full[1] == (i == `WAITERS_PER_PIPE)) else begin
                $display("mismatch at %0t: waiter load %0d rfull %b", $time, i, full[1]);
                errors++;
            end
        end
        hold_ar = 0;
        drain("waiter_full");

        tests++;
        $display("test refill done, %0d refills checked, errors so far %0d", refills, errors);
        errors += u_dcache_miss.u_props.fail_cnt;
        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+.
miss_pkg.sv
miss_table.sv
load_waiter_bank.sv
line_fetcher.sv
dcache_miss.sv
dcache_miss_props.sv
tb_dcache_miss.sv

// File: Makefile
SIM = obj_dir/Vtb_dcache_miss
SRCS = miss_defs.svh miss_pkg.sv miss_table.sv load_waiter_bank.sv line_fetcher.sv \
       dcache_miss.sv dcache_miss_props.sv tb_dcache_miss.sv

.PHONY: all run clean

all: $(SIM)

$(SIM): files.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_dcache_miss -f files.f

sim.log: $(SIM)
	./$(SIM) +verilator+error+limit+1000 > sim.log 2>&1 || true

run: sim.log
	cat sim.log
	@if grep -q "RESULT: FAIL" sim.log; then exit 1; fi
	@grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
